// File: list.f
+incdir+testbench
hdl/rs_pkg.sv
hdl/rs_eras_syndrome_count_root.sv
hdl/rs_frame_buffer.sv
hdl/rs_eras_locator.sv
hdl/rs_frame_ctrl.sv
hdl/rs_eras_frontend.sv
testbench/tb_rs_eras_frontend.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rs_eras_frontend
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/tb_rs_ref.svh
`ifndef TB_RS_REF_SVH
`define TB_RS_REF_SVH

// shift and add multiply, no log tables
function automatic data_t field_mul(input data_t a, input data_t b);
  logic [m:0] sh;
  data_t      acc;
  acc = '0;
  sh  = {1'b0, a};
  for (int k = 0; k < m; k++) begin
    if (b[k]) acc = acc ^ sh[m-1:0];
    sh = sh << 1;
    if (sh[m]) sh = sh ^ (m+1)'(irrpol); // reduce by field polynomial
  end
  return acc;
endfunction

function automatic data_t field_pow(input int e);
  data_t x;
  x = data_t'(1);
  for (int k = 0; k < e % gf_n_max; k++) x = field_mul(x, data_t'(2)); // alpha is x
  return x;
endfunction

// position 0 is sent first and has the highest power
function automatic data_t root_of_pos(input int pos);
  return field_pow(rootspace * (n - 1 - pos));
endfunction

// direct power sum per check root, S_i in slice i-1
function automatic logic [check*m-1:0] syndromes_of(input data_t d [0:n-1]);
  logic [check*m-1:0] s;
  data_t              acc;
  for (int i = 1; i <= check; i++) begin
    acc = '0;
    for (int k = 0; k < n; k++) begin
      acc = acc ^ field_mul(d[k], field_pow(((genstart + i - 1) * rootspace * (n - 1 - k)) % gf_n_max));
    end
    s[(i-1)*m +: m] = acc;
  end
  return s;
endfunction

// product of (1 + r*x) over the newest check erasures
function automatic logic [(check+1)*m-1:0] locator_of(input logic fl [0:n-1]);
  logic [(check+1)*m-1:0] p;
  data_t                  c [0:check];
  data_t                  r;
  int                     used;
  used = 0;
  for (int j = 0; j <= check; j++) c[j] = (j == 0) ? data_t'(1) : '0;
  for (int k = n - 1; k >= 0; k--) begin
    if (fl[k] && used < check) begin
      r = root_of_pos(k);
      for (int j = check; j >= 1; j--) c[j] = c[j] ^ field_mul(r, c[j-1]);
      used++;
    end
  end
  for (int j = 0; j <= check; j++) p[j*m +: m] = c[j];
  return p;
endfunction

// systematic parity, slice j lands on symbol n-check+j
function automatic logic [check*m-1:0] parity_of(input data_t d [0:n-1]);
  logic [check*m-1:0] par;
  data_t              g [0:check];
  data_t              r [0:check-1];
  data_t              a;
  data_t              fb;
  for (int j = 0; j <= check; j++) g[j] = (j == 0) ? data_t'(1) : '0;
  for (int i = 1; i <= check; i++) begin
    a = field_pow((genstart + i - 1) * rootspace);
    for (int j = check; j >= 1; j--) g[j] = g[j-1] ^ field_mul(a, g[j]); // g * (x + a)
    g[0] = field_mul(a, g[0]);
  end
  for (int j = 0; j < check; j++) r[j] = '0;
  for (int k = 0; k < n - check; k++) begin
    fb = d[k] ^ r[check-1];
    for (int j = check - 1; j >= 1; j--) r[j] = r[j-1] ^ field_mul(fb, g[j]);
    r[0] = field_mul(fb, g[0]);
  end
  for (int j = 0; j < check; j++) par[j*m +: m] = r[check-1-j];
  return par;
endfunction

`endif

// File: testbench/tb_rs_eras_frontend.sv
`timescale 1ns/1ns

module tb_rs_eras_frontend;

  import rs_pkg::*;

  `include "tb_rs_ref.svh"

  localparam int clk_period   = 4;
  localparam int reset_cycles = 10;
  localparam int total_frames = 24;
  localparam int frame_gap    = 8;  // drain margin per frame
  localparam int ena_factor   = 3;  // worst stretch with iclkena dropping out
  localparam int watchdog_ns  =
    (reset_cycles + total_frames * (n + frame_gap) * ena_factor) * clk_period;

  logic  iclk = 1'b0;
  logic  iclkena, ireset, isop, ival, ieop, ieras;
  data_t idat;
  logic  oresult_val, oeras_overflow, osop, oval, oeop;
  data_t osyndrome  [1:check];
  poly_t oeras_poly [0:check];
  data_t oeras_num, odat;

  int seed          = 32'h28fa973a;
  int ena_cnt       = 0;  // enabled edges since reset
  int res_frames    = 0;
  int stream_frames = 0;
  int word_idx      = 0;  // position inside replayed frame

  logic [check*m-1:0]     syn_q  [$];  // expected records, one per frame
  logic [(check+1)*m-1:0] poly_q [$];
  int                     num_q  [$];
  int                     ieop_q [$];  // enabled edge of each ieop word
  data_t                  data_q [$];  // expected replay symbols

  rs_eras_frontend i_dut (
    .iclk (iclk), .iclkena (iclkena), .ireset (ireset),
    .isop (isop), .ival (ival), .ieop (ieop), .idat (idat), .ieras (ieras),
    .oresult_val (oresult_val), .osyndrome (osyndrome), .oeras_poly (oeras_poly),
    .oeras_num (oeras_num), .oeras_overflow (oeras_overflow),
    .osop (osop), .oval (oval), .oeop (oeop), .odat (odat)
  );

  always #(clk_period / 2) iclk = ~iclk;

  //----------------------------------------------------------
  // error reporting
  //----------------------------------------------------------

  task automatic stop_with_error(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
                              input string what);
    if (got !== want) begin
      $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
    end
  endtask

  initial begin
    #(watchdog_ns);
    stop_with_error("watchdog expired, results or replay never completed");
  end

  //----------------------------------------------------------
  // stimulus
  //----------------------------------------------------------

  task automatic idle_cycle();
    @(posedge iclk);
    iclkena <= 1'b1;
    ival    <= 1'b0;
    isop    <= 1'b0;
    ieop    <= 1'b0;
    ieras   <= 1'b0;
  endtask

  // word accepted on the next edge, after 0..2 disabled cycles if asked
  task automatic put_word(input logic sop, input logic eop, input data_t sym,
                          input logic era, input bit ena_rand);
    int gaps;
    gaps = ena_rand ? $unsigned($random(seed)) % 3 : 0;
    repeat (gaps) begin
      @(posedge iclk);
      iclkena <= 1'b0;
      ival    <= 1'b0;
    end
    @(posedge iclk);
    iclkena <= 1'b1;
    isop    <= sop;
    ival    <= 1'b1;
    ieop    <= eop;
    idat    <= sym;
    ieras   <= era;
  endtask

  // kind 0 clean codeword, 1 up to check erasures, 2 overflow
  task automatic send_frame(input int kind, input bit ena_rand);
    data_t              d  [0:n-1];
    logic               fl [0:n-1];
    logic [check*m-1:0] par;
    int                 want_eras;
    int                 cnt;
    int                 pos;
    for (int k = 0; k < n; k++) begin
      d[k]  = data_t'($random(seed));
      fl[k] = 1'b0;
    end
    case (kind)
      0       : want_eras = 0;
      1       : want_eras = $unsigned($random(seed)) % (check + 1);
      default : want_eras = check + 1 + $unsigned($random(seed)) % (n - check);
    endcase
    if (kind == 0) begin
      par = parity_of(d);
      for (int j = 0; j < check; j++) d[n-check+j] = par[j*m +: m];
    end
    cnt = 0;
    while (cnt < want_eras) begin  // distinct flagged positions
      pos = $unsigned($random(seed)) % n;
      if (!fl[pos]) begin
        fl[pos] = 1'b1;
        cnt++;
      end
    end
    syn_q.push_back(kind == 0 ? '0 : syndromes_of(d)); // codeword checks to zero
    poly_q.push_back(locator_of(fl));
    num_q.push_back(cnt);
    for (int k = 0; k < n; k++) data_q.push_back(d[k]);
    for (int k = 0; k < n; k++) put_word(k == 0, k == n - 1, d[k], fl[k], ena_rand);
  endtask

  function automatic int frame_kind(input int f);
    if (f < 3) return 0;
    if (f < 11) return 1;
    if (f < 14) return 2;
    return f % 3; // mixed, with iclkena toggling
  endfunction

  //----------------------------------------------------------
  // compare
  //----------------------------------------------------------

  task automatic compare_result();
    logic [check*m-1:0]     want_syn;
    logic [(check+1)*m-1:0] want_poly;
    int                     want_num;
    int                     t_eop;
    if (syn_q.size() == 0 || ieop_q.size() == 0) begin
      stop_with_error("result pulse without a frame waiting for it");
    end else begin
      want_syn  = syn_q.pop_front();
      want_poly = poly_q.pop_front();
      want_num  = num_q.pop_front();
      t_eop     = ieop_q.pop_front();
      for (int i = 1; i <= check; i++) begin
        expect_equal(32'(osyndrome[i]), 32'(want_syn[(i-1)*m +: m]),
                     $sformatf("frame %0d syndrome %0d", res_frames, i));
      end
      for (int j = 0; j <= check; j++) begin
        expect_equal(32'(oeras_poly[j]), 32'(want_poly[j*m +: m]),
                     $sformatf("frame %0d locator coeff %0d", res_frames, j));
      end
      expect_equal(32'(oeras_num), want_num, $sformatf("frame %0d erasure count", res_frames));
      expect_equal(32'(oeras_overflow), 32'(want_num > check),
                   $sformatf("frame %0d overflow", res_frames));
      expect_equal(ena_cnt - t_eop, 3 + ((want_num > check) ? check : want_num),
                   $sformatf("frame %0d result latency", res_frames));
      res_frames++;
    end
  endtask

  task automatic stream_word_check();
    data_t want_sym;
    if (data_q.size() == 0) begin
      stop_with_error("replay word without a frame behind it");
    end else begin
      want_sym = data_q.pop_front();
      expect_equal(32'(odat), 32'(want_sym),
                   $sformatf("frame %0d word %0d symbol", stream_frames, word_idx));
      expect_equal(32'(osop), 32'(word_idx == 0),
                   $sformatf("frame %0d word %0d osop", stream_frames, word_idx));
      expect_equal(32'(oeop), 32'(word_idx == n - 1),
                   $sformatf("frame %0d word %0d oeop", stream_frames, word_idx));
      if (word_idx == n - 1) begin
        word_idx = 0;
        stream_frames++;
      end else begin
        word_idx++;
      end
    end
  endtask

  always @(posedge iclk) begin
    if (!ireset && iclkena) begin   // one look per enabled cycle
      ena_cnt++;
      if (ival && ieop) ieop_q.push_back(ena_cnt);
      if (oresult_val) compare_result();
      if (oval) stream_word_check();
    end
  end

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------

  initial begin
    iclkena = 1'b0;
    ireset  = 1'b1;
    isop    = 1'b0;
    ival    = 1'b0;
    ieop    = 1'b0;
    idat    = '0;
    ieras   = 1'b0;
    repeat (reset_cycles) @(posedge iclk);
    ireset <= 1'b0;
    repeat (2) idle_cycle();
    for (int f = 0; f < total_frames; f++) begin
      send_frame(frame_kind(f), f >= 14); // back to back, minimum gap
    end
    while (res_frames < total_frames || stream_frames < total_frames) idle_cycle();
    repeat (8) idle_cycle(); // stray pulses would pop an empty queue
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: hdl/rs_eras_frontend.sv
`timescale 1ns/1ns

// top of the erasure decoder input stage

module rs_eras_frontend (
  input  logic          iclk,
  input  logic          iclkena,
  input  logic          ireset,
  input  logic          isop,
  input  logic          ival,
  input  logic          ieop,
  input  rs_pkg::data_t idat,
  input  logic          ieras,
  output logic          oresult_val,
  output rs_pkg::data_t osyndrome  [1:rs_pkg::check],
  output rs_pkg::poly_t oeras_poly [0:rs_pkg::check],
  output rs_pkg::data_t oeras_num,
  output logic          oeras_overflow,
  output logic          osop,
  output logic          oval,
  output logic          oeop,
  output rs_pkg::data_t odat
);

  import rs_pkg::*;

  //----------------------------------------------------------
  // internal nets
  //----------------------------------------------------------

  data_t ram_addr;        // write side
  ptr_t  ram_ptr;
  data_t ram_data;
  logic  ram_write;
  logic  syndrome_val;
  ptr_t  syndrome_ptr;
  data_t syndrome  [1:check];
  data_t eras_root [1:check];
  data_t eras_num;
  logic  loc_start;       // locator handshake
  data_t loc_count;
  logic  loc_done;
  poly_t poly      [0:check];
  logic  rd_en;           // replay side
  ptr_t  rd_ptr;
  data_t rd_addr;
  data_t rd_data;

  rs_eras_syndrome_count_root i_count (
    .iclk (iclk), .iclkena (iclkena), .ireset (ireset),
    .isop (isop), .ival (ival), .ieop (ieop), .idat (idat), .ieras (ieras),
    .ram_addr (ram_addr), .ram_ptr (ram_ptr), .ram_data (ram_data),
    .ram_write (ram_write), .syndrome_val (syndrome_val),
    .syndrome_ptr (syndrome_ptr), .syndrome (syndrome),
    .eras_root (eras_root), .eras_num (eras_num)
  );

  rs_frame_buffer i_buffer (
    .iclk (iclk), .iclkena (iclkena),
    .wr_en (ram_write), .wr_ptr (ram_ptr), .wr_addr (ram_addr), .wr_data (ram_data),
    .rd_en (rd_en), .rd_ptr (rd_ptr), .rd_addr (rd_addr), .rd_data (rd_data)
  );

  rs_eras_locator i_locator (
    .iclk (iclk), .iclkena (iclkena), .ireset (ireset),
    .loc_start (loc_start), .loc_count (loc_count), .eras_root (eras_root),
    .loc_done (loc_done), .poly (poly)
  );

  rs_frame_ctrl i_ctrl (
    .iclk (iclk), .iclkena (iclkena), .ireset (ireset),
    .syndrome_val (syndrome_val), .syndrome_ptr (syndrome_ptr), .syndrome (syndrome),
    .eras_num (eras_num), .loc_done (loc_done), .poly (poly), .rd_data (rd_data),
    .loc_start (loc_start), .loc_count (loc_count),
    .rd_en (rd_en), .rd_ptr (rd_ptr), .rd_addr (rd_addr),
    .oresult_val (oresult_val), .osyndrome (osyndrome), .oeras_poly (oeras_poly),
    .oeras_num (oeras_num), .oeras_overflow (oeras_overflow),
    .osop (osop), .oval (oval), .oeop (oeop), .odat (odat)
  );

endmodule

// File: hdl/rs_frame_ctrl.sv
`timescale 1ns/1ns

// frame sequencing: locator start, result capture, buffer replay

module rs_frame_ctrl (
  input  logic          iclk,
  input  logic          iclkena,
  input  logic          ireset,
  input  logic          syndrome_val,
  input  rs_pkg::ptr_t  syndrome_ptr,
  input  rs_pkg::data_t syndrome   [1:rs_pkg::check],
  input  rs_pkg::data_t eras_num,
  input  logic          loc_done,
  input  rs_pkg::poly_t poly       [0:rs_pkg::check],
  input  rs_pkg::data_t rd_data,
  output logic          loc_start,
  output rs_pkg::data_t loc_count,
  output logic          rd_en,
  output rs_pkg::ptr_t  rd_ptr,
  output rs_pkg::data_t rd_addr,
  output logic          oresult_val,
  output rs_pkg::data_t osyndrome  [1:rs_pkg::check],
  output rs_pkg::poly_t oeras_poly [0:rs_pkg::check],
  output rs_pkg::data_t oeras_num,
  output logic          oeras_overflow,
  output logic          osop,
  output logic          oval,
  output logic          oeop,
  output rs_pkg::data_t odat
);

  import rs_pkg::*;

  frame_state_t state;
  ptr_t         rd_bank;  // bank under replay
  data_t        rd_cnt;   // next replay address
  logic         rd_busy;

  //----------------------------------------------------------
  // result FSM
  //----------------------------------------------------------

  assign loc_start = syndrome_val; // same tick as the syndromes
  assign loc_count = (eras_num > data_t'(check)) ? data_t'(check) : eras_num;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= idle;
    end else if (iclkena) begin
      case (state)
        idle    : if (syndrome_val) state <= build;
        build   : if (loc_done) state <= hold;
        hold    : state <= syndrome_val ? build : idle;
        default : state <= idle;
      endcase
    end
  end

  assign oresult_val = (state == hold); // one tick after loc_done

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (syndrome_val) begin
        osyndrome      <= syndrome;
        oeras_num      <= eras_num;
        oeras_overflow <= (eras_num > data_t'(check));
      end
      if (loc_done) begin
        oeras_poly <= poly;
      end
    end
  end

  //----------------------------------------------------------
  // replay, word 0 read on the syndrome_val tick
  //----------------------------------------------------------

  assign rd_en   = syndrome_val | rd_busy;
  assign rd_ptr  = syndrome_val ? syndrome_ptr : rd_bank;
  assign rd_addr = syndrome_val ? '0 : rd_cnt;
  assign odat    = rd_data;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_busy <= 1'b0;
      rd_cnt  <= '0;
      rd_bank <= '0;
      oval    <= 1'b0;
      osop    <= 1'b0;
      oeop    <= 1'b0;
    end else if (iclkena) begin
      if (syndrome_val) begin
        rd_busy <= 1'b1;
        rd_cnt  <= data_t'(1);
        rd_bank <= syndrome_ptr;
      end else if (rd_busy) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == data_t'(n - 1)) begin
          rd_busy <= 1'b0; // last word issued
        end
      end
      // strobes ride one tick behind to match the ram read
      oval <= rd_en;
      osop <= syndrome_val;
      oeop <= rd_en & (rd_addr == data_t'(n - 1));
    end
  end

  // a new frame while the locator still runs breaks the input rule
  a_no_overrun : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && syndrome_val) |-> (state != build)
  ) else $error("frame ended while previous result still building");

endmodule

// File: hdl/rs_eras_locator.sv
`timescale 1ns/1ns

// erasure locator builder
// poly = prod (1 + r*x), one root folded in per enabled cycle

module rs_eras_locator (
  input  logic          iclk,
  input  logic          iclkena,
  input  logic          ireset,
  input  logic          loc_start,
  input  rs_pkg::data_t loc_count,
  input  rs_pkg::data_t eras_root [1:rs_pkg::check],
  output logic          loc_done,
  output rs_pkg::poly_t poly      [0:rs_pkg::check]
);

  import rs_pkg::*;

  data_t root_q [1:check];  // local copy, consumed from index 1
  data_t step_cnt;          // roots still to fold in
  logic  busy;

  // done once the step counter has drained
  assign loc_done = busy & (step_cnt == '0);

  //----------------------------------------------------------
  // step control
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy     <= 1'b0;
      step_cnt <= '0;
    end else if (iclkena) begin
      if (loc_start) begin
        busy     <= 1'b1;
        step_cnt <= loc_count;
      end else if (busy) begin
        if (step_cnt == '0) begin
          busy <= 1'b0;
        end else begin
          step_cnt <= step_cnt - 1'b1;
        end
      end
    end
  end

  //----------------------------------------------------------
  // polynomial datapath
  //----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (loc_start) begin
        for (int j = 0; j <= check; j++) begin
          poly[j] <= (j == 0) ? poly_t'(1) : '0; // start from 1
        end
        for (int i = 1; i <= check; i++) begin
          root_q[i] <= eras_root[i];
        end
      end else if (busy && step_cnt != '0) begin
        // p(x) * (1 + r*x), poly[0] stays 1
        for (int j = 1; j <= check; j++) begin
          poly[j] <= poly[j] ^ gf_mult(root_q[1], poly[j-1]);
        end
        for (int i = 1; i < check; i++) begin
          root_q[i] <= root_q[i+1]; // next root to the front
        end
        root_q[check] <= '0;
      end
    end
  end

  a_loc_count_max : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && loc_start) |-> (loc_count <= data_t'(check))
  ) else $error("locator asked for more roots than check symbols");

endmodule

// File: hdl/rs_frame_buffer.sv
`timescale 1ns/1ns

// two bank symbol ram, one write port, registered read port

module rs_frame_buffer (
  input  logic          iclk,
  input  logic          iclkena,
  input  logic          wr_en,
  input  rs_pkg::ptr_t  wr_ptr,
  input  rs_pkg::data_t wr_addr,
  input  rs_pkg::data_t wr_data,
  input  logic          rd_en,
  input  rs_pkg::ptr_t  rd_ptr,
  input  rs_pkg::data_t rd_addr,
  output rs_pkg::data_t rd_data
);

  import rs_pkg::*;

  data_t mem [0:1][0:n-1]; // bank x address

  always_ff @(posedge iclk) begin
    if (iclkena && wr_en) begin
      mem[wr_ptr][wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && rd_en) begin
      rd_data <= mem[rd_ptr][rd_addr]; // data one enabled tick later
    end
  end

  // the ieop word lands while replay of its bank starts at word 0,
  // so only a same-word collision is a real hazard
  a_no_collision : assert property (
    @(posedge iclk)
    (iclkena && wr_en && rd_en) |-> !(wr_ptr == rd_ptr && wr_addr == rd_addr)
  ) else $error("read and write hit the same buffer word");

endmodule

// File: hdl/rs_eras_syndrome_count_root.sv
`timescale 1ns/1ns

// syndromes, erasure roots and erasure count of one frame,
// plus the write stream into the frame buffer

module rs_eras_syndrome_count_root (
  input  logic          iclk,
  input  logic          iclkena,
  input  logic          ireset,
  input  logic          isop,
  input  logic          ival,
  input  logic          ieop,
  input  rs_pkg::data_t idat,
  input  logic          ieras,
  output rs_pkg::data_t ram_addr,
  output rs_pkg::ptr_t  ram_ptr,
  output rs_pkg::data_t ram_data,
  output logic          ram_write,
  output logic          syndrome_val,
  output rs_pkg::ptr_t  syndrome_ptr,
  output rs_pkg::data_t syndrome  [1:rs_pkg::check],
  output rs_pkg::data_t eras_root [1:rs_pkg::check],
  output rs_pkg::data_t eras_num
);

  import rs_pkg::*;

  data_t first_root_pos;   // root of the first symbol in the frame
  data_t rootspace_inv;    // alpha^-rootspace
  data_t eras_state;       // root of the last accepted symbol
  data_t eras_state_next;  // root of the symbol on idat now

  assign first_root_pos = alpha_to((rootspace * (n - 1)) % gf_n_max);
  assign rootspace_inv  = alpha_to((gf_n_max - (rootspace % gf_n_max)) % gf_n_max);

  assign eras_state_next = isop ? first_root_pos : gf_mult(eras_state, rootspace_inv);

  //----------------------------------------------------------
  // syndromes, horner form
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syndrome_val <= 1'b0;
    end else if (iclkena) begin
      syndrome_val <= ival & ieop; // one tick after the last word
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      for (int i = 1; i <= check; i++) begin
        // s = s * root_i + d, restart on sop
        syndrome[i] <= isop ? idat :
          (idat ^ gf_mult(syndrome[i], alpha_to(((genstart + i - 1) * rootspace) % gf_n_max)));
      end
    end
  end

  //----------------------------------------------------------
  // erasure roots and count
  //----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      eras_state <= eras_state_next;
      for (int i = 1; i <= check; i++) begin
        if (isop) begin
          eras_root[i] <= (i == 1 && ieras) ? eras_state_next : '0; // fresh chain
        end else if (ieras) begin
          eras_root[i] <= (i == 1) ? eras_state_next : eras_root[i-1]; // newest first
        end
      end
      if (isop) begin
        eras_num <= data_t'(ieras);
      end else if (ieras) begin
        eras_num <= eras_num + 1'b1;
      end
    end
  end

  //----------------------------------------------------------
  // buffer write stream, one tick behind the input
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ram_write <= 1'b0;
      ram_ptr   <= '0;
    end else if (iclkena) begin
      ram_write <= ival;
      if (ival && isop) begin
        ram_ptr <= ~ram_ptr; // new bank per frame
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      ram_data <= idat;
      ram_addr <= isop ? '0 : ram_addr + 1'b1;
    end
  end

  // the last word is still being written when syndrome_val is up,
  // so the write pointer already names the finished bank
  assign syndrome_ptr = ram_ptr;

  // counter may not step past a full frame of erasures
  a_eras_num_max : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival && !isop && ieras) |-> (eras_num < data_t'(n))
  ) else $error("erasure count overflows frame length");

endmodule

// File: hdl/rs_pkg.sv
// shared code constants, symbol types and GF(2^m) helpers
// for the erasure decoder input stage

package rs_pkg;

  //----------------------------------------------------------
  // code parameters
  //----------------------------------------------------------

  localparam int m         = 4;   // bits per symbol
  localparam int n         = 15;  // frame length in symbols
  localparam int check     = 4;   // number of check symbols
  localparam int irrpol    = 19;  // x^4 + x + 1
  localparam int genstart  = 0;   // first root exponent
  localparam int rootspace = 1;   // spacing between roots

  localparam int gf_n_max  = 2**m - 1; // multiplicative group order

  //----------------------------------------------------------
  // types
  //----------------------------------------------------------

  typedef logic [m-1:0] data_t;   // symbol, also address and count
  typedef logic         ptr_t;    // buffer bank select
  typedef logic [m-1:0] poly_t;   // locator coefficient

  typedef enum logic [1:0] {
    idle,
    build,
    hold
  } frame_state_t;

  //----------------------------------------------------------
  // field arithmetic
  //----------------------------------------------------------

  // alpha^power, walks the lfsr from 1
  function automatic data_t alpha_to(input int power);
    data_t acc;
    int    p;
    acc = data_t'(1);
    p   = power % gf_n_max;
    for (int i = 0; i < gf_n_max; i++) begin
      if (i < p) begin
        // multiply by x, reduce when the top bit falls out
        acc = acc[m-1] ? data_t'((acc << 1) ^ irrpol) : data_t'(acc << 1);
      end
    end
    return acc;
  endfunction

  // discrete log, zero maps to 0 but is never used as a log
  function automatic int index_of(input data_t a);
    int log_a;
    log_a = 0;
    for (int i = 0; i < gf_n_max; i++) begin
      if (alpha_to(i) == a) begin
        log_a = i;
      end
    end
    return log_a;
  endfunction

  // a * b through the log tables
  function automatic data_t gf_mult(input data_t a, input data_t b);
    if (a == '0 || b == '0) begin
      return '0;
    end
    return alpha_to(index_of(a) + index_of(b)); // exponent wraps inside alpha_to
  endfunction

endpackage
